/* Bender.yml */
package:
  name: bimodal_predictor

sources:
  - source/BranchPredTypes.sv
  - source/PhtRam.sv
  - source/PhtUpdateQueue.sv
  - source/PhtUpdateArbiter.sv
  - source/PhtLookup.sv
  - source/BimodalPredictor.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/BimodalPredictorTb.sv

/* BimodalPredictor.f */
+incdir+dv
source/BranchPredTypes.sv
source/PhtRam.sv
source/PhtUpdateQueue.sv
source/PhtUpdateArbiter.sv
source/PhtLookup.sv
source/BimodalPredictor.sv
dv/BimodalPredictorTb.sv

/* dv/PhtModel.svh */
/*
 * Reference model of the bimodal predictor, included inside the testbench.
 * Keeps a shadow counter table and the deferred writes still in flight.
 */
`ifndef PHT_MODEL_SVH
`define PHT_MODEL_SVH

PhtEntry shadow [PhtEntryNum];
PhtIndex pendIndex [$];
PhtEntry pendValue [$];

function automatic PhtIndex indexOf(input PcPath pc);
    return PhtIndex'(pc >> InsnOffsetWidth);
endfunction

function automatic PhtEntry nextCounter(input PhtEntry prev, input logic taken);
    if (taken) begin
        return (prev < PhtEntryMax) ? PhtEntry'(prev + 1) : prev;
    end
    return (prev > 0) ? PhtEntry'(prev - 1) : prev;
endfunction

// Top bit and a BTB hit give taken, nothing after the first taken slot.
function automatic logic [FetchWidth-1:0] predictSlots(input PhtEntry [FetchWidth-1:0] value,
        input logic [FetchWidth-1:0] hit);
    logic [FetchWidth-1:0] taken;
    taken[0] = value[0][PhtEntryWidth-1] && hit[0];
    taken[1] = !taken[0] && value[1][PhtEntryWidth-1] && hit[1];
    return taken;
endfunction

function automatic void applyResults(input logic [IssueWidth-1:0] valid, input PcPath pc0,
        input PcPath pc1, input logic [IssueWidth-1:0] taken, input logic cancel,
        input PhtEntry prev0, input PhtEntry prev1);
    logic portUsed;
    PhtIndex headIdx;
    portUsed = 1'b0;
    if (valid[0]) begin
        shadow[indexOf(pc0)] = nextCounter(prev0, taken[0]);
        portUsed = 1'b1;
    end
    // Lane 1 waits in the queue when lane 0 holds the port.
    if (valid[1] && !(valid[0] && cancel)) begin
        if (!portUsed) begin
            shadow[indexOf(pc1)] = nextCounter(prev1, taken[1]);
            portUsed = 1'b1;
        end else if (pendIndex.size() < PhtQueueSize) begin
            pendIndex.push_back(indexOf(pc1));
            pendValue.push_back(nextCounter(prev1, taken[1]));
        end
    end
    // A free port retires the oldest deferred write.
    if (!portUsed && pendIndex.size() > 0) begin
        headIdx = pendIndex.pop_front();
        shadow[headIdx] = pendValue.pop_front();
    end
endfunction

`endif

/* dv/BimodalPredictorTb.sv */
/*
 * Testbench of the bimodal predictor. Drives lookups and branch results
 * on the falling edge and checks every lookup against the reference model.
 */
`timescale 1ns/1ps

module BimodalPredictorTb import BranchPredTypes::*; ();

    logic clock = 1'b0;
    logic reset;
    PcPath predNextPc;
    logic [FetchWidth-1:0] btbHit;
    logic [FetchWidth-1:0] brPredTaken;
    PhtEntry [FetchWidth-1:0] phtPrevValue;
    logic [IssueWidth-1:0] brValid;
    PcPath [IssueWidth-1:0] brPc;
    logic [IssueWidth-1:0] brTaken;
    logic [IssueWidth-1:0] brMispred;
    PhtEntry [IssueWidth-1:0] brPrevValue;
    logic initDone;

    integer seed = 32'h6a49_ded6;
    logic lookValid;
    logic stagedValid;
    PhtEntry [FetchWidth-1:0] lookExp;
    PhtEntry [FetchWidth-1:0] stagedExp;
    int waitCount;

    `include "PhtModel.svh"

    BimodalPredictor BimodalPredictor_inst (.*);

    always #4 clock = ~clock;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    // One cycle of stimulus with the model stepped alongside.
    task automatic driveCycle(input logic look, input PcPath pc, input logic [1:0] hit,
            input logic [1:0] valid, input PcPath pc0, input PcPath pc1,
            input logic [1:0] taken, input logic [1:0] mispred);
        @(negedge clock);
        predNextPc = pc;
        btbHit = hit;
        brValid = valid;
        brPc = {pc1, pc0};
        brTaken = taken;
        brMispred = mispred;
        brPrevValue = {shadow[indexOf(pc1)], shadow[indexOf(pc0)]};
        lookValid = look;
        // A read beside a write sees the old counter.
        lookExp = {shadow[indexOf(pc + InsnByteWidth)], shadow[indexOf(pc)]};
        applyResults(valid, pc0, pc1, taken, mispred[0], brPrevValue[0], brPrevValue[1]);
    endtask

    task automatic idleCycle(input logic [1:0] hit);
        driveCycle(1'b0, '0, hit, '0, '0, '0, '0, '0);
    endtask

    task automatic waitDrain();
        waitCount = 0;
        idleCycle(2'($random(seed)));
        while (!BimodalPredictor_inst.empty && waitCount < PhtQueueSize + 8) begin
            idleCycle(2'($random(seed)));
            waitCount++;
        end
        assert (BimodalPredictor_inst.empty && pendIndex.size() == 0) else
            failRun("Update queue did not drain in time");
    endtask

    // Two slots per lookup cover the whole table.
    task automatic readBack();
        for (int k = 0; k < PhtEntryNum / FetchWidth; k++) begin
            driveCycle(1'b1, PcPath'(k * FetchWidth * InsnByteWidth), 2'($random(seed)),
                '0, '0, '0, '0, '0);
        end
        idleCycle(2'b11);
    endtask

    // Lookup of cycle N is checked at the edge that ends cycle N+1.
    always @(posedge clock) begin : compareOutputs
        logic [FetchWidth-1:0] expTaken;
        if (stagedValid) begin
            for (int i = 0; i < FetchWidth; i++) begin
                assert (phtPrevValue[i] === stagedExp[i]) else
                    failRun($sformatf("Error at %0t: slot %0d counter is %0d, expected %0d",
                        $time, i, phtPrevValue[i], stagedExp[i]));
            end
            expTaken = predictSlots(stagedExp, btbHit);
            assert (brPredTaken === expTaken) else
                failRun($sformatf("Error at %0t: prediction is %b, expected %b",
                    $time, brPredTaken, expTaken));
        end
        stagedValid = lookValid;
        stagedExp = lookExp;
    end

    initial begin
        reset = 1'b1;
        predNextPc = '0;
        btbHit = '0;
        brValid = '0;
        brPc = '0;
        brTaken = '0;
        brMispred = '0;
        brPrevValue = '0;
        lookValid = 1'b0;
        stagedValid = 1'b0;
        lookExp = '0;
        stagedExp = '0;
        for (int i = 0; i < PhtEntryNum; i++) begin
            shadow[i] = PhtEntry'(PhtInitValue);
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        assert (!initDone) else failRun("initDone was high during reset");
        reset = 1'b0;
        waitCount = 0;
        while (!initDone && waitCount < PhtEntryNum + 8) begin
            @(negedge clock);
            waitCount++;
        end
        assert (initDone) else failRun("initDone did not rise after the reset sweep");
        readBack();

        // Saturation at both ends on a single branch.
        repeat (4) driveCycle(1'b1, 32'h100, 2'b01, 2'b01, 32'h100, '0, 2'b01, '0);
        repeat (5) driveCycle(1'b1, 32'h100, 2'b01, 2'b01, 32'h100, '0, 2'b00, '0);
        idleCycle(2'b01);

        // Both slots end strongly taken and slot 0 masks slot 1.
        driveCycle(1'b0, '0, 2'b00, 2'b11, 32'h208, 32'h20c, 2'b11, 2'b00);
        waitDrain();
        driveCycle(1'b1, 32'h208, 2'b11, '0, '0, '0, '0, '0);
        idleCycle(2'b11);

        // Overfilling the queue loses the last two lane 1 updates.
        for (int k = 0; k < PhtQueueSize + 2; k++) begin
            driveCycle(1'b0, '0, 2'b00, 2'b11, 32'h300, PcPath'(32'h340 + 4 * k),
                2'b10, 2'b00);
        end
        waitDrain();
        readBack();

        // A lane 0 misprediction keeps lane 1 from writing.
        driveCycle(1'b0, '0, 2'b00, 2'b11, 32'h400, 32'h404, 2'b10, 2'b01);
        waitDrain();
        readBack();

        for (int round = 0; round < 8; round++) begin
            repeat (24) begin
                driveCycle(1'($random(seed)), PcPath'($random(seed) & 32'hfc),
                    2'($random(seed)), 2'($random(seed)), PcPath'($random(seed) & 32'h3c),
                    PcPath'($random(seed) & 32'h3c), 2'($random(seed)), 2'($random(seed)));
            end
            waitDrain();
            readBack();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* source/BimodalPredictor.sv */
/*
 * Bimodal branch direction predictor for a two-wide fetch unit.
 * Connects the lookup logic, the counter table, the write arbiter
 * and the deferred update queue.
 */
`timescale 1ns/1ps

module BimodalPredictor import BranchPredTypes::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  PcPath                     predNextPc,
    input  logic    [FetchWidth-1:0]  btbHit,
    output logic    [FetchWidth-1:0]  brPredTaken,
    output PhtEntry [FetchWidth-1:0]  phtPrevValue,
    input  logic    [IssueWidth-1:0]  brValid,
    input  PcPath   [IssueWidth-1:0]  brPc,
    input  logic    [IssueWidth-1:0]  brTaken,
    input  logic    [IssueWidth-1:0]  brMispred,
    input  PhtEntry [IssueWidth-1:0]  brPrevValue,
    output logic                      initDone
);

    PhtIndex [FetchWidth-1:0] readIndex;

    logic    writeEnable;
    PhtIndex writeIndex;
    PhtEntry writeValue;

    logic    push;
    PhtIndex pushIndex;
    PhtEntry pushValue;
    logic    pop;
    PhtIndex headIndex;
    PhtEntry headValue;
    logic    empty;

    PhtLookup lookup (
        .predNextPc  (predNextPc),
        .readIndex   (readIndex),
        .readValue   (phtPrevValue),
        .btbHit      (btbHit),
        .brPredTaken (brPredTaken)
    );

    // Read data also leaves the top level so fetch can return it with the branch result.
    PhtRam pht (
        .clock       (clock),
        .readIndex   (readIndex),
        .readValue   (phtPrevValue),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeValue  (writeValue)
    );

    PhtUpdateArbiter arbiter (
        .clock       (clock),
        .reset       (reset),
        .brValid     (brValid),
        .brPc        (brPc),
        .brTaken     (brTaken),
        .brMispred   (brMispred),
        .brPrevValue (brPrevValue),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeValue  (writeValue),
        .push        (push),
        .pushIndex   (pushIndex),
        .pushValue   (pushValue),
        .pop         (pop),
        .headIndex   (headIndex),
        .headValue   (headValue),
        .empty       (empty),
        .initDone    (initDone)
    );

    // Overflowing updates are dropped inside the queue.
    PhtUpdateQueue updateQueue (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .pushIndex (pushIndex),
        .pushValue (pushValue),
        .pop       (pop),
        .headIndex (headIndex),
        .headValue (headValue),
        .full      (),
        .empty     (empty)
    );

endmodule

/* source/BranchPredTypes.sv */
/*
 * Widths, table sizes and vector types of the bimodal branch predictor.
 * Every predictor module imports this package with a wildcard import
 * in its header.
 */
package BranchPredTypes;

    // Program counter and instruction layout.
    localparam int PcWidth = 32;
    localparam int InsnByteWidth = 4;
    localparam int InsnOffsetWidth = 2;

    // Pattern history table geometry.
    localparam int PhtEntryNum = 64;
    localparam int PhtIndexWidth = 6;
    localparam int PhtEntryWidth = 2;
    localparam int PhtEntryMax = 3;

    // Weakly taken.
    localparam int PhtInitValue = 2;

    // Lanes on the fetch side and on the retire side.
    localparam int FetchWidth = 2;
    localparam int IssueWidth = 2;

    // Deferred update queue.
    localparam int PhtQueueSize = 4;
    localparam int PhtQueuePtrWidth = 2;

    typedef logic [PcWidth-1:0] PcPath;
    typedef logic [PhtIndexWidth-1:0] PhtIndex;
    typedef logic [PhtEntryWidth-1:0] PhtEntry;
    typedef logic [PhtQueuePtrWidth-1:0] PhtQueuePtr;

    // Sweep fills the table after reset, Run serves branch results.
    typedef enum logic {
        Sweep,
        Run
    } ArbiterState;

endpackage

/* source/PhtLookup.sv */
/*
 * Fetch side of the predictor.
 * Forms one table index per fetch slot from the fetch PC, and one cycle
 * later turns the returned counters and BTB hits into taken predictions,
 * keeping only the first taken slot.
 */
`timescale 1ns/1ps

module PhtLookup import BranchPredTypes::*; (
    input  PcPath                    predNextPc,
    output PhtIndex [FetchWidth-1:0] readIndex,
    input  PhtEntry [FetchWidth-1:0] readValue,
    input  logic    [FetchWidth-1:0] btbHit,
    output logic    [FetchWidth-1:0] brPredTaken
);

    PcPath [FetchWidth-1:0] slotPc;
    logic takenSeen;

    // Consecutive instructions of the fetch group.
    always_comb begin
        for (int i = 0; i < FetchWidth; i++) begin
            slotPc[i] = predNextPc + PcPath'(i * InsnByteWidth);
            readIndex[i] = slotPc[i][PhtIndexWidth+InsnOffsetWidth-1:InsnOffsetWidth];
        end
    end

    // Counter top bit says taken, but only a BTB hit makes it a branch.
    always_comb begin
        takenSeen = 1'b0;
        for (int i = 0; i < FetchWidth; i++) begin
            brPredTaken[i] = !takenSeen && readValue[i][PhtEntryWidth-1] && btbHit[i];
            // Slots behind a taken branch are never reached.
            takenSeen = takenSeen | brPredTaken[i];
        end
    end

endmodule

/* source/PhtRam.sv */
/*
 * Counter storage of the pattern history table.
 * One registered read port per fetch lane and a single write port;
 * a read that meets a write to the same entry returns the old value.
 */
`timescale 1ns/1ps

module PhtRam import BranchPredTypes::*; (
    input  logic                       clock,
    input  PhtIndex [FetchWidth-1:0]   readIndex,
    output PhtEntry [FetchWidth-1:0]   readValue,
    input  logic                       writeEnable,
    input  PhtIndex                    writeIndex,
    input  PhtEntry                    writeValue
);

    // No reset here. The arbiter sweeps every entry after reset.
    PhtEntry entries [PhtEntryNum];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            entries[writeIndex] <= writeValue;
        end
    end

    // Nonblocking reads sample the array before this edge's write.
    always_ff @(posedge clock) begin
        for (int i = 0; i < FetchWidth; i++) begin
            readValue[i] <= entries[readIndex[i]];
        end
    end

endmodule

/* source/PhtUpdateArbiter.sv */
/*
 * Owner of the table's write port.
 * Sweeps the table to weakly taken after reset, then turns retired
 * branch results into saturated counter writes, deferring the second
 * lane into the update queue and draining it when the port is idle.
 */
`timescale 1ns/1ps

module PhtUpdateArbiter import BranchPredTypes::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic    [IssueWidth-1:0]  brValid,
    input  PcPath   [IssueWidth-1:0]  brPc,
    input  logic    [IssueWidth-1:0]  brTaken,
    input  logic    [IssueWidth-1:0]  brMispred,
    input  PhtEntry [IssueWidth-1:0]  brPrevValue,
    output logic                      writeEnable,
    output PhtIndex                   writeIndex,
    output PhtEntry                   writeValue,
    output logic                      push,
    output PhtIndex                   pushIndex,
    output PhtEntry                   pushValue,
    output logic                      pop,
    input  PhtIndex                   headIndex,
    input  PhtEntry                   headValue,
    input  logic                      empty,
    output logic                      initDone
);

    ArbiterState state;
    PhtIndex sweepIndex;

    PhtIndex [IssueWidth-1:0] laneIndex;
    PhtEntry [IssueWidth-1:0] laneValue;

    logic    directValid;
    PhtIndex directIndex;
    PhtEntry directValue;
    logic    deferValid;
    logic    laneCancel;

    // Table index and saturated next value for every result lane.
    always_comb begin
        for (int i = 0; i < IssueWidth; i++) begin
            laneIndex[i] = brPc[i][PhtIndexWidth+InsnOffsetWidth-1:InsnOffsetWidth];
            if (brTaken[i]) begin
                laneValue[i] = (brPrevValue[i] == PhtEntryMax) ?
                    brPrevValue[i] : brPrevValue[i] + 1'b1;
            end else begin
                laneValue[i] = (brPrevValue[i] == '0) ?
                    brPrevValue[i] : brPrevValue[i] - 1'b1;
            end
        end
    end

    // Lanes in program order. A mispredicted lane squashes younger ones.
    always_comb begin
        directValid = 1'b0;
        directIndex = laneIndex[0];
        directValue = laneValue[0];
        deferValid = 1'b0;
        laneCancel = 1'b0;
        for (int i = 0; i < IssueWidth; i++) begin
            if (brValid[i] && !laneCancel) begin
                if (!directValid) begin
                    directValid = 1'b1;
                    directIndex = laneIndex[i];
                    directValue = laneValue[i];
                end else begin
                    deferValid = 1'b1;
                end
                laneCancel = brMispred[i];
            end
        end
    end

    // Only the last lane ever goes to the queue.
    assign pushIndex = laneIndex[IssueWidth-1];
    assign pushValue = laneValue[IssueWidth-1];
    assign push = (state == Run) && deferValid;

    // Write port priority: sweep, then direct result, then queue head.
    always_comb begin
        writeEnable = 1'b0;
        writeIndex = directIndex;
        writeValue = directValue;
        pop = 1'b0;
        if (state == Sweep) begin
            writeEnable = 1'b1;
            writeIndex = sweepIndex;
            writeValue = PhtEntry'(PhtInitValue);
        end else if (directValid) begin
            writeEnable = 1'b1;
        end else if (!empty) begin
            writeEnable = 1'b1;
            writeIndex = headIndex;
            writeValue = headValue;
            pop = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= Sweep;
            sweepIndex <= '0;
        end else if (state == Sweep) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == PhtIndex'(PhtEntryNum - 1)) begin
                state <= Run;
            end
        end
    end

    assign initDone = (state == Run);

endmodule

/* source/PhtUpdateQueue.sv */
/*
 * Small circular buffer for counter writes that lost the write port.
 * The head entry is visible combinationally; a push into a full
 * queue is dropped, and push and pop may happen in the same cycle.
 */
`timescale 1ns/1ps

module PhtUpdateQueue import BranchPredTypes::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    push,
    input  PhtIndex pushIndex,
    input  PhtEntry pushValue,
    input  logic    pop,
    output PhtIndex headIndex,
    output PhtEntry headValue,
    output logic    full,
    output logic    empty
);

    PhtIndex queueIndex [PhtQueueSize];
    PhtEntry queueValue [PhtQueueSize];

    PhtQueuePtr headPtr;
    PhtQueuePtr tailPtr;

    // One extra bit so that a full queue can be told from an empty one.
    logic [PhtQueuePtrWidth:0] count;

    logic pushAccept;
    logic popAccept;

    assign full = (count == PhtQueueSize);
    assign empty = (count == '0);

    assign pushAccept = push && !full;
    assign popAccept = pop && !empty;

    assign headIndex = queueIndex[headPtr];
    assign headValue = queueValue[headPtr];

    // Payload storage.
    always_ff @(posedge clock) begin
        if (pushAccept) begin
            queueIndex[tailPtr] <= pushIndex;
            queueValue[tailPtr] <= pushValue;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (pushAccept) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (popAccept) begin
                headPtr <= headPtr + 1'b1;
            end
            count <= count + pushAccept - popAccept;
        end
    end

endmodule
